//--- include/gpr_params.svh
`ifndef GPR_PARAMS_SVH
`define GPR_PARAMS_SVH

// ******************************
// warp geometry
// ******************************

`define NUM_THREADS 4 // lanes per warp.

// ******************************
// register banks
// ******************************

`define NUM_REGS 32 // registers per bank.
`define NR_BITS 5 // register address width.
`define WORD_BITS 32 // one lane.

// single-precision -0, used as rs3 when an instruction has no third source.
`define FP_NEG_ZERO 32'h8000_0000

`endif

//--- logic/gpr_types_pkg.sv
`default_nettype none

`include "gpr_params.svh"

package gpr_types_pkg;

	// ******************************
	// data path
	// ******************************

	typedef logic [`WORD_BITS-1:0] word_t; // one lane.

	typedef logic [`NR_BITS-1:0] reg_addr_t; // register index.

	// one operand vector, lane 0 in the low word.
	typedef word_t [`NUM_THREADS-1:0] warp_data_t;

	// ******************************
	// read sequence
	// ******************************

	// RD_THIRD reuses fp read port 1 for rs3.
	typedef enum logic {
		RD_FIRST,
		RD_THIRD
	} rd_state_e;

endpackage

`default_nettype wire

//--- logic/decode_pkg.sv
`default_nettype none

package decode_pkg;

	// ******************************
	// instruction fields
	// ******************************

	localparam int PC_BITS = 32;
	localparam int IMM_BITS = 32;
	localparam int TAG_BITS = 8;

	typedef logic [PC_BITS-1:0] pc_t; // program counter.

	typedef logic [IMM_BITS-1:0] imm_t; // sign-extended by decode.

	// matches a result back to its instruction.
	typedef logic [TAG_BITS-1:0] tag_t;

endpackage

`default_nettype wire

//--- logic/decode_if.sv
`timescale 1ns/100ps
`default_nettype none

interface decode_if;
	import gpr_types_pkg::*;
	import decode_pkg::*;

	logic      dec_valid; // decode register holds an instruction.
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rs3;
	logic      rs1_is_fp;
	logic      rs2_is_fp;
	logic      rs1_is_pc; // broadcast pc in place of rs1.
	logic      rs2_is_imm; // broadcast imm in place of rs2.
	logic      use_rs3; // fused op, needs a second read cycle.
	pc_t       pc;
	imm_t      imm;

	modport src (
		output dec_valid, rs1, rs2, rs3,
		output rs1_is_fp, rs2_is_fp, rs1_is_pc, rs2_is_imm, use_rs3,
		output pc, imm
	);

	modport ctrl (
		input dec_valid, rs1, rs2, rs3,
		input rs1_is_fp, rs2_is_fp, rs1_is_pc, rs2_is_imm, use_rs3,
		input pc, imm
	);

endinterface

`default_nettype wire

//--- logic/gpr_data_if.sv
`timescale 1ns/100ps
`default_nettype none

interface gpr_data_if;
	import gpr_types_pkg::*;

	// operand vectors as selected by the read controller.
	warp_data_t rs1_data;
	warp_data_t rs2_data;
	warp_data_t rs3_data;

	modport src (
		output rs1_data,
		output rs2_data,
		output rs3_data
	);

	modport sink (
		input rs1_data,
		input rs2_data,
		input rs3_data
	);

endinterface

`default_nettype wire

//--- logic/gpr_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "gpr_params.svh"

module gpr_bank #(
	parameter bit HAS_ZERO_REG = 1'b0
) (
	input  logic                      clk,
	input  logic                      reset,
	input  gpr_types_pkg::reg_addr_t  raddr1,
	input  gpr_types_pkg::reg_addr_t  raddr2,
	input  logic                      wr_en,
	input  gpr_types_pkg::reg_addr_t  wr_addr,
	input  gpr_types_pkg::warp_data_t wr_data,
	output gpr_types_pkg::warp_data_t rdata1,
	output gpr_types_pkg::warp_data_t rdata2
);
	import gpr_types_pkg::*;

	warp_data_t regs [`NUM_REGS];
	logic       wr_allowed;

	// x0 is hardwired on the int side.
	assign wr_allowed = wr_en && !(HAS_ZERO_REG && (wr_addr == '0));

	// ******************************
	// write port
	// ******************************

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_allowed) begin
			regs[wr_addr] <= wr_data; // all lanes at once.
		end
	end

	// ******************************
	// read ports
	// ******************************

	// no bypass, a write shows up the cycle after.
	always_comb begin
		rdata1 = regs[raddr1];
		rdata2 = regs[raddr2];
		if (HAS_ZERO_REG && (raddr1 == '0)) begin
			rdata1 = '0;
		end
		if (HAS_ZERO_REG && (raddr2 == '0)) begin
			rdata2 = '0;
		end
	end

endmodule

`default_nettype wire

//--- logic/gpr_fp_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "gpr_params.svh"

module gpr_fp_ctrl (
	input  logic                      clk,
	input  logic                      reset,
	decode_if.ctrl                    dec_if,
	input  gpr_types_pkg::warp_data_t rs1_int_data,
	input  gpr_types_pkg::warp_data_t rs2_int_data,
	input  gpr_types_pkg::warp_data_t rs1_fp_data,
	input  gpr_types_pkg::warp_data_t rs2_fp_data,
	output gpr_types_pkg::reg_addr_t  raddr1,
	output gpr_types_pkg::reg_addr_t  raddr2,
	gpr_data_if.src                   data_if,
	input  logic                      schedule_delay,
	output logic                      gpr_delay
);
	import gpr_types_pkg::*;

	rd_state_e  state;
	logic       advance;
	warp_data_t sel_rs1;
	warp_data_t sel_rs2;
	warp_data_t tmp_rs1;
	warp_data_t tmp_rs2;

	// ******************************
	// read sequence
	// ******************************

	// the state only moves while the output side can take a result.
	assign advance = dec_if.dec_valid && !schedule_delay;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RD_FIRST;
		end else if (advance) begin
			case (state)
				RD_FIRST: state <= dec_if.use_rs3 ? RD_THIRD : RD_FIRST;
				RD_THIRD: state <= RD_FIRST;
				default:  state <= RD_FIRST;
			endcase
		end
	end

	// holds the instruction one more cycle for the rs3 read.
	assign gpr_delay = dec_if.dec_valid && dec_if.use_rs3 && (state == RD_FIRST);

	// fp port 1 fetches rs3 in the second cycle.
	assign raddr1 = (state == RD_THIRD) ? dec_if.rs3 : dec_if.rs1;
	assign raddr2 = dec_if.rs2;

	// ******************************
	// source selection
	// ******************************

	always_comb begin
		if (dec_if.rs1_is_fp) begin
			sel_rs1 = rs1_fp_data;
		end else if (dec_if.rs1_is_pc) begin
			sel_rs1 = {`NUM_THREADS{dec_if.pc}}; // same pc in every lane.
		end else begin
			sel_rs1 = rs1_int_data;
		end

		if (dec_if.rs2_is_fp) begin
			sel_rs2 = rs2_fp_data;
		end else if (dec_if.rs2_is_imm) begin
			sel_rs2 = {`NUM_THREADS{dec_if.imm}};
		end else begin
			sel_rs2 = rs2_int_data;
		end
	end

	// rs1 and rs2 of a fused op, kept while port 1 is busy with rs3.
	always_ff @(posedge clk) begin
		if (advance && (state == RD_FIRST)) begin
			tmp_rs1 <= sel_rs1;
			tmp_rs2 <= sel_rs2;
		end
	end

	always_comb begin
		if (dec_if.use_rs3) begin
			data_if.rs1_data = tmp_rs1;
			data_if.rs2_data = tmp_rs2;
			data_if.rs3_data = rs1_fp_data; // valid in RD_THIRD only.
		end else begin
			data_if.rs1_data = sel_rs1;
			data_if.rs2_data = sel_rs2;
			data_if.rs3_data = {`NUM_THREADS{`FP_NEG_ZERO}};
		end
	end

endmodule

`default_nettype wire

//--- logic/gpr_read_stage.sv
`timescale 1ns/100ps
`default_nettype none

module gpr_read_stage (
	input  logic                      clk,
	input  logic                      reset,

	// decoded instruction in.
	input  logic                      in_valid,
	output logic                      in_ready,
	input  gpr_types_pkg::reg_addr_t  in_rs1,
	input  gpr_types_pkg::reg_addr_t  in_rs2,
	input  gpr_types_pkg::reg_addr_t  in_rs3,
	input  logic                      in_rs1_is_fp,
	input  logic                      in_rs2_is_fp,
	input  logic                      in_rs1_is_pc,
	input  logic                      in_rs2_is_imm,
	input  logic                      in_use_rs3,
	input  decode_pkg::pc_t           in_pc,
	input  decode_pkg::imm_t          in_imm,
	input  decode_pkg::tag_t          in_tag,

	// writeback.
	input  logic                      int_wr_en,
	input  gpr_types_pkg::reg_addr_t  int_wr_addr,
	input  gpr_types_pkg::warp_data_t int_wr_data,
	input  logic                      fp_wr_en,
	input  gpr_types_pkg::reg_addr_t  fp_wr_addr,
	input  gpr_types_pkg::warp_data_t fp_wr_data,

	// operands out.
	output logic                      out_valid,
	input  logic                      out_ready,
	output gpr_types_pkg::warp_data_t out_rs1_data,
	output gpr_types_pkg::warp_data_t out_rs2_data,
	output gpr_types_pkg::warp_data_t out_rs3_data,
	output decode_pkg::tag_t          out_tag
);
	import gpr_types_pkg::*;
	import decode_pkg::*;

	decode_if   dec_if ();
	gpr_data_if data_if ();

	reg_addr_t  raddr1;
	reg_addr_t  raddr2;
	warp_data_t rs1_int_data;
	warp_data_t rs2_int_data;
	warp_data_t rs1_fp_data;
	warp_data_t rs2_fp_data;
	logic       gpr_delay;
	logic       schedule_delay;
	logic       out_load;
	logic       in_fire;
	tag_t       dec_tag;

	// ******************************
	// handshakes
	// ******************************

	assign schedule_delay = out_valid && !out_ready; // output register stuck.
	assign out_load = dec_if.dec_valid && !gpr_delay && !schedule_delay;
	assign in_ready = !dec_if.dec_valid || out_load;
	assign in_fire = in_valid && in_ready;

	// ******************************
	// decode register
	// ******************************

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_if.dec_valid <= 1'b0;
		end else if (in_ready) begin
			dec_if.dec_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			dec_if.rs1 <= in_rs1;
			dec_if.rs2 <= in_rs2;
			dec_if.rs3 <= in_rs3;
			dec_if.rs1_is_fp <= in_rs1_is_fp;
			dec_if.rs2_is_fp <= in_rs2_is_fp;
			dec_if.rs1_is_pc <= in_rs1_is_pc;
			dec_if.rs2_is_imm <= in_rs2_is_imm;
			dec_if.use_rs3 <= in_use_rs3;
			dec_if.pc <= in_pc;
			dec_if.imm <= in_imm;
			dec_tag <= in_tag; // stays at the top, the controller never needs it.
		end
	end

	// ******************************
	// register banks
	// ******************************

	gpr_bank #(
		.HAS_ZERO_REG (1'b1)
	) u_int_bank (
		.clk     (clk),
		.reset   (reset),
		.raddr1  (raddr1),
		.raddr2  (raddr2),
		.wr_en   (int_wr_en),
		.wr_addr (int_wr_addr),
		.wr_data (int_wr_data),
		.rdata1  (rs1_int_data),
		.rdata2  (rs2_int_data)
	);

	gpr_bank #(
		.HAS_ZERO_REG (1'b0)
	) u_fp_bank (
		.clk     (clk),
		.reset   (reset),
		.raddr1  (raddr1),
		.raddr2  (raddr2),
		.wr_en   (fp_wr_en),
		.wr_addr (fp_wr_addr),
		.wr_data (fp_wr_data),
		.rdata1  (rs1_fp_data),
		.rdata2  (rs2_fp_data)
	);

	gpr_fp_ctrl u_fp_ctrl (
		.clk            (clk),
		.reset          (reset),
		.dec_if         (dec_if.ctrl),
		.rs1_int_data   (rs1_int_data),
		.rs2_int_data   (rs2_int_data),
		.rs1_fp_data    (rs1_fp_data),
		.rs2_fp_data    (rs2_fp_data),
		.raddr1         (raddr1),
		.raddr2         (raddr2),
		.data_if        (data_if.src),
		.schedule_delay (schedule_delay),
		.gpr_delay      (gpr_delay)
	);

	// ******************************
	// output register
	// ******************************

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (out_load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// loads only when empty or draining, so a stalled result holds.
	always_ff @(posedge clk) begin
		if (out_load) begin
			out_rs1_data <= data_if.rs1_data;
			out_rs2_data <= data_if.rs2_data;
			out_rs3_data <= data_if.rs3_data;
			out_tag <= dec_tag;
		end
	end

endmodule

`default_nettype wire

//--- test/gpr_read_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "gpr_params.svh"

module gpr_read_stage_tb;
	import gpr_types_pkg::*;
	import decode_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int CYCLES_PER_LINE = 40;
	localparam int DRIVE_DELAY = 1; // after the rising edge.
	localparam string PATTERN_FILE = "test/gpr_read_stage_patterns.txt";

	// one writeback or one instruction with its expected operands.
	typedef struct packed {
		logic       is_write;
		logic       wr_fp;
		reg_addr_t  wr_addr;
		warp_data_t wr_data;
		tag_t       tag;
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		reg_addr_t  rs3;
		logic       rs1_is_fp;
		logic       rs2_is_fp;
		logic       rs1_is_pc;
		logic       rs2_is_imm;
		logic       use_rs3;
		pc_t        pc;
		imm_t       imm;
		warp_data_t exp_rs1;
		warp_data_t exp_rs2;
		warp_data_t exp_rs3;
	} cmd_t;

	logic       clk = 1'b0;
	logic       reset;
	logic       in_valid;
	logic       in_ready;
	reg_addr_t  in_rs1;
	reg_addr_t  in_rs2;
	reg_addr_t  in_rs3;
	logic       in_rs1_is_fp;
	logic       in_rs2_is_fp;
	logic       in_rs1_is_pc;
	logic       in_rs2_is_imm;
	logic       in_use_rs3;
	pc_t        in_pc;
	imm_t       in_imm;
	tag_t       in_tag;
	logic       int_wr_en;
	reg_addr_t  int_wr_addr;
	warp_data_t int_wr_data;
	logic       fp_wr_en;
	reg_addr_t  fp_wr_addr;
	warp_data_t fp_wr_data;
	logic       out_valid;
	logic       out_ready;
	warp_data_t out_rs1_data;
	warp_data_t out_rs2_data;
	warp_data_t out_rs3_data;
	tag_t       out_tag;

	cmd_t cmd_q[$];
	cmd_t pending_q[$]; // accepted but not yet returned.
	int   n_lines = 0;
	logic loaded = 1'b0;

	gpr_read_stage u_gpr_read_stage (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ******************************
	// checks
	// ******************************

	task automatic report_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_operand(input warp_data_t actual, input warp_data_t expected,
			input string what);
		if (actual !== expected) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
			report_failure();
		end
	endtask

	task automatic check_tag(input tag_t actual, input tag_t expected, input string what);
		if (actual !== expected) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
			report_failure();
		end
	endtask

	// ******************************
	// pattern file
	// ******************************

	task automatic load_patterns();
		int          fd;
		int          n;
		int          sel;
		byte         kind;
		string       line;
		logic [31:0] v [11];
		word_t       w [4];
		cmd_t        cmd;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("cannot open pattern file %s", PATTERN_FILE);
			report_failure();
		end
		cmd = '0;
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			kind = (line.len() > 0) ? line.getc(0) : "#";
			if (kind == "W") begin
				n = $sscanf(line, "W %h %h %h %h %h %h", v[0], v[1], w[0], w[1], w[2], w[3]);
				if (n != 6) begin
					$display("malformed writeback line: %s", line);
					report_failure();
				end
				cmd = '0;
				cmd.is_write = 1'b1;
				cmd.wr_fp = v[0][0];
				cmd.wr_addr = v[1][`NR_BITS-1:0];
				cmd.wr_data = {w[3], w[2], w[1], w[0]}; // lane 0 low.
				cmd_q.push_back(cmd);
				n_lines++;
			end else if (kind == "I") begin
				n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
					v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
				if (n != 11) begin
					$display("malformed instruction line: %s", line);
					report_failure();
				end
				cmd = '0;
				cmd.tag = v[0][7:0];
				cmd.rs1 = v[1][`NR_BITS-1:0];
				cmd.rs2 = v[2][`NR_BITS-1:0];
				cmd.rs3 = v[3][`NR_BITS-1:0];
				cmd.rs1_is_fp = v[4][0];
				cmd.rs2_is_fp = v[5][0];
				cmd.rs1_is_pc = v[6][0];
				cmd.rs2_is_imm = v[7][0];
				cmd.use_rs3 = v[8][0];
				cmd.pc = v[9];
				cmd.imm = v[10];
				n_lines++;
			end else if (kind == "E") begin
				n = $sscanf(line, "E %d %h %h %h %h", sel, w[0], w[1], w[2], w[3]);
				if (n != 5 || sel < 1 || sel > 3) begin
					$display("malformed expected-value line: %s", line);
					report_failure();
				end
				case (sel)
					1: cmd.exp_rs1 = {w[3], w[2], w[1], w[0]};
					2: cmd.exp_rs2 = {w[3], w[2], w[1], w[0]};
					default: begin
						cmd.exp_rs3 = {w[3], w[2], w[1], w[0]};
						cmd_q.push_back(cmd); // rs3 closes the instruction.
					end
				endcase
				n_lines++;
			end else if (kind != "#" && kind != "\n" && kind != " ") begin
				$display("unknown line in pattern file: %s", line);
				report_failure();
			end
		end
		$fclose(fd);
	endtask

	// ******************************
	// drivers
	// ******************************

	task automatic wait_for_drain();
		while (pending_q.size() != 0) begin
			@(posedge clk);
			#(DRIVE_DELAY);
		end
	endtask

	task automatic apply_write(input cmd_t cmd);
		if (cmd.wr_fp) begin
			fp_wr_en = 1'b1;
			fp_wr_addr = cmd.wr_addr;
			fp_wr_data = cmd.wr_data;
		end else begin
			int_wr_en = 1'b1;
			int_wr_addr = cmd.wr_addr;
			int_wr_data = cmd.wr_data;
		end
		@(posedge clk);
		#(DRIVE_DELAY);
		int_wr_en = 1'b0;
		fp_wr_en = 1'b0;
	endtask

	task automatic issue_instr(input cmd_t cmd);
		in_valid = 1'b1;
		in_rs1 = cmd.rs1;
		in_rs2 = cmd.rs2;
		in_rs3 = cmd.rs3;
		in_rs1_is_fp = cmd.rs1_is_fp;
		in_rs2_is_fp = cmd.rs2_is_fp;
		in_rs1_is_pc = cmd.rs1_is_pc;
		in_rs2_is_imm = cmd.rs2_is_imm;
		in_use_rs3 = cmd.use_rs3;
		in_pc = cmd.pc;
		in_imm = cmd.imm;
		in_tag = cmd.tag;
		@(negedge clk);
		while (!in_ready) begin
			@(negedge clk);
		end
		pending_q.push_back(cmd); // taken at the coming edge.
		@(posedge clk);
		#(DRIVE_DELAY);
		in_valid = 1'b0;
	endtask

	initial begin
		int i;
		reset = 1'b1;
		in_valid = 1'b0;
		in_rs1 = '0;
		in_rs2 = '0;
		in_rs3 = '0;
		in_rs1_is_fp = 1'b0;
		in_rs2_is_fp = 1'b0;
		in_rs1_is_pc = 1'b0;
		in_rs2_is_imm = 1'b0;
		in_use_rs3 = 1'b0;
		in_pc = '0;
		in_imm = '0;
		in_tag = '0;
		int_wr_en = 1'b0;
		int_wr_addr = '0;
		int_wr_data = '0;
		fp_wr_en = 1'b0;
		fp_wr_addr = '0;
		fp_wr_data = '0;
		void'($urandom(32'h71d5a54e));
		load_patterns();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		reset = 1'b0;
		for (i = 0; i < cmd_q.size(); i++) begin
			if (cmd_q[i].is_write) begin
				wait_for_drain(); // nothing in flight reads the old value.
				apply_write(cmd_q[i]);
			end else begin
				issue_instr(cmd_q[i]);
			end
		end
		wait_for_drain();
		repeat (4) @(posedge clk); // a stray result would show up here.
		$display("ALL TESTS PASSED");
		$finish;
	end

	// ******************************
	// result side
	// ******************************

	initial begin
		int         stall;
		logic       held;
		warp_data_t held_rs1;
		warp_data_t held_rs2;
		warp_data_t held_rs3;
		tag_t       held_tag;
		cmd_t       want;
		stall = 0;
		held = 1'b0;
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#(DRIVE_DELAY);
			out_ready = (stall == 0);
			if (stall > 0) begin
				stall--;
			end
			@(negedge clk);
			if (held) begin
				if (!out_valid) begin
					$display("out_valid dropped at %0t while out_ready was low", $time);
					report_failure();
				end
				check_operand(out_rs1_data, held_rs1, "stalled rs1");
				check_operand(out_rs2_data, held_rs2, "stalled rs2");
				check_operand(out_rs3_data, held_rs3, "stalled rs3");
				check_tag(out_tag, held_tag, "stalled out_tag");
			end
			held = out_valid && !out_ready;
			held_rs1 = out_rs1_data;
			held_rs2 = out_rs2_data;
			held_rs3 = out_rs3_data;
			held_tag = out_tag;
			if (out_valid && out_ready) begin
				if (pending_q.size() == 0) begin
					$display("result with tag %h at %0t has no instruction behind it",
						out_tag, $time);
					report_failure();
				end
				want = pending_q.pop_front();
				check_tag(out_tag, want.tag, "out_tag");
				check_operand(out_rs1_data, want.exp_rs1, $sformatf("rs1 of tag %h", want.tag));
				check_operand(out_rs2_data, want.exp_rs2, $sformatf("rs2 of tag %h", want.tag));
				check_operand(out_rs3_data, want.exp_rs3, $sformatf("rs3 of tag %h", want.tag));
				stall = $urandom % 4; // back-pressure before the next result.
			end
		end
	end

	// hang guard scaled to the pattern length.
	initial begin
		wait (loaded);
		#((n_lines * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
		$display("watchdog expired at %0t, the stage stopped returning results", $time);
		report_failure();
	end

endmodule

`default_nettype wire

//--- gpr_read_stage.f
+incdir+include
logic/gpr_types_pkg.sv
logic/decode_pkg.sv
logic/decode_if.sv
logic/gpr_data_if.sv
logic/gpr_bank.sv
logic/gpr_fp_ctrl.sv
logic/gpr_read_stage.sv
test/gpr_read_stage_tb.sv

//--- test/gpr_read_stage_patterns.txt
# W <0 int, 1 fp> <reg> <lane0> <lane1> <lane2> <lane3>
# I <tag> <rs1> <rs2> <rs3> <rs1_is_fp> <rs2_is_fp> <rs1_is_pc> <rs2_is_imm> <use_rs3> <pc> <imm>
# E <1, 2 or 3 for rs1, rs2, rs3> <lane0> <lane1> <lane2> <lane3>, three after each I line
W 0 01 11110001 11110002 11110003 11110004
W 0 02 22220001 22220002 22220003 22220004
W 0 01 0000aaaa 0000bbbb 0000cccc 0000dddd
W 0 00 deadbeef deadbeef deadbeef deadbeef
W 1 00 3f800000 40000000 40400000 40800000
W 1 03 bf800000 c0000000 c0400000 c0800000
W 1 07 41200000 41a00000 41f00000 42200000
I 01 01 02 00 0 0 0 0 0 00000000 00000000
E 1 0000aaaa 0000bbbb 0000cccc 0000dddd
E 2 22220001 22220002 22220003 22220004
E 3 80000000 80000000 80000000 80000000
I 02 00 01 00 0 0 0 0 0 00000000 00000000
E 1 00000000 00000000 00000000 00000000
E 2 0000aaaa 0000bbbb 0000cccc 0000dddd
E 3 80000000 80000000 80000000 80000000
I 03 03 00 07 1 1 0 0 1 00000000 00000000
E 1 bf800000 c0000000 c0400000 c0800000
E 2 3f800000 40000000 40400000 40800000
E 3 41200000 41a00000 41f00000 42200000
I 04 05 06 00 0 0 1 1 0 00001000 fffffff0
E 1 00001000 00001000 00001000 00001000
E 2 fffffff0 fffffff0 fffffff0 fffffff0
E 3 80000000 80000000 80000000 80000000
I 05 07 04 00 1 0 0 1 1 00000000 00000010
E 1 41200000 41a00000 41f00000 42200000
E 2 00000010 00000010 00000010 00000010
E 3 3f800000 40000000 40400000 40800000
I 06 02 03 00 0 1 0 0 0 00000000 00000000
E 1 22220001 22220002 22220003 22220004
E 2 bf800000 c0000000 c0400000 c0800000
E 3 80000000 80000000 80000000 80000000
W 1 03 00000001 00000002 00000003 00000004
W 0 02 12345678 9abcdef0 0f0f0f0f f0f0f0f0
I 07 02 02 00 0 0 0 0 0 00000000 00000000
E 1 12345678 9abcdef0 0f0f0f0f f0f0f0f0
E 2 12345678 9abcdef0 0f0f0f0f f0f0f0f0
E 3 80000000 80000000 80000000 80000000
I 08 00 07 03 1 1 0 0 1 00000000 00000000
E 1 3f800000 40000000 40400000 40800000
E 2 41200000 41a00000 41f00000 42200000
E 3 00000001 00000002 00000003 00000004
I 09 01 03 03 0 1 1 0 1 00002004 00000000
E 1 00002004 00002004 00002004 00002004
E 2 00000001 00000002 00000003 00000004
E 3 00000001 00000002 00000003 00000004
I 0a 00 00 00 0 0 0 0 0 00000000 00000000
E 1 00000000 00000000 00000000 00000000
E 2 00000000 00000000 00000000 00000000
E 3 80000000 80000000 80000000 80000000
